//--- vgaTimingPkg.sv
package vgaTimingPkg;

	////////////////////////////////////////////////////////////////////////////
	// 640x480 raster at a 25 MHz pixel clock
	////////////////////////////////////////////////////////////////////////////

	// one counter width for both axes
	// 800 columns still fit in ten bits
	typedef logic [9:0] scanCount;

	// pixel clocks per line, sync included
	localparam int hTotalDefault = 800;
	// lines per frame
	localparam int vTotalDefault = 521;

	// sync pulse lengths, counted from position 0
	localparam int hPulseDefault = 96;
	localparam int vPulseDefault = 2;

	// first active column
	localparam int hBackPorch = 144;
	// first column past the active area
	localparam int hFrontPorch = 784;

	// first active line
	localparam int vBackPorch = 31;
	// first line past the active area
	localparam int vFrontPorch = 511;

	// active area is therefore 640 columns by 480 lines

endpackage

//--- glyphArtPkg.sv
package glyphArtPkg;

	// one decimal digit
	typedef logic [3:0] bcdDigit;
	// one bit per stroke, top stroke in the msb
	typedef logic [6:0] segWord;
	// rrr ggg bb
	typedef logic [7:0] pixelColor;

	// stroke bit positions inside a segWord
	localparam int segTop = 6;
	localparam int segUpLeft = 5;
	localparam int segUpRight = 4;
	localparam int segMiddle = 3;
	localparam int segLowLeft = 2;
	localparam int segLowRight = 1;
	localparam int segBottom = 0;

	////////////////////////////////////////////////////////////////////////////
	// glyphs
	////////////////////////////////////////////////////////////////////////////

	// indexed by digit value
	localparam segWord digitGlyphs [10] = '{
		7'b1110111, 7'b0010010, 7'b1011101, 7'b1011011, 7'b0111010,
		7'b1101011, 7'b1101111, 7'b1010010, 7'b1111111, 7'b1111011
	};
	localparam segWord glyphBlank = 7'b0000000;
	// letters for the two messages
	localparam segWord glyphU = 7'b0110111;
	localparam segWord glyphR = 7'b0001100;
	localparam segWord glyphB = 7'b0101111;
	// two of these side by side make a W
	localparam segWord glyphWHalf = 7'b0110111;
	// same strokes as a 1
	localparam segWord glyphI = 7'b0010010;
	localparam segWord glyphN = 7'b1110110;

	////////////////////////////////////////////////////////////////////////////
	// slot layout
	////////////////////////////////////////////////////////////////////////////

	localparam int slotCount = 4;
	localparam int slotWidth = 80;
	localparam int strokeWidth = 5;
	// rows below vBackPorch
	localparam int glyphTop = 255;
	// top stroke to middle stroke, middle to bottom
	localparam int halfHeight = 80;

	// left to right: white, yellow, cyan, green
	localparam pixelColor slotPalette [slotCount] = '{8'hFF, 8'hFC, 8'h1F, 8'h1C};

	// balances from here on show the win message
	localparam int winThreshold = 1000;

endpackage

//--- balanceSplitter.sv
`timescale 1ns/1ps

module balanceSplitter
	import glyphArtPkg::*;
(
	input logic dclk,
	input logic clr,
	input logic [26:0] balance,
	output bcdDigit digitThousands,
	output bcdDigit digitHundreds,
	output bcdDigit digitTens,
	output bcdDigit digitOnes,
	output logic atWin,
	output logic atBust
);

	// only the low four decimal places are shown
	logic [26:0] lowPart;

	assign lowPart = balance % 27'd10000;

	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			digitThousands <= '0;
			digitHundreds <= '0;
			digitTens <= '0;
			digitOnes <= '0;
			atWin <= 1'b0;
			atBust <= 1'b0;
		end
		else
		begin
			// lowPart below 10000, so each quotient fits a digit
			digitThousands <= bcdDigit'(lowPart / 27'd1000);
			digitHundreds <= bcdDigit'((lowPart / 27'd100) % 27'd10);
			digitTens <= bcdDigit'((lowPart / 27'd10) % 27'd10);
			digitOnes <= bcdDigit'(lowPart % 27'd10);
			// flags use the full balance, not the shown part
			atWin <= (balance >= 27'(winThreshold));
			atBust <= (balance == '0);
		end
	end

	// the divider must never hand on a non-decimal nibble
	digitsDecimal: assert property (@(posedge dclk) disable iff (clr)
		digitThousands <= 4'd9 && digitHundreds <= 4'd9 &&
		digitTens <= 4'd9 && digitOnes <= 4'd9);

endmodule

//--- glyphSelector.sv
`timescale 1ns/1ps

module glyphSelector
	import glyphArtPkg::*;
(
	input logic dclk,
	input logic clr,
	input bcdDigit digitThousands,
	input bcdDigit digitHundreds,
	input bcdDigit digitTens,
	input bcdDigit digitOnes,
	input logic atWin,
	input logic atBust,
	output segWord slotGlyph0,
	output segWord slotGlyph1,
	output segWord slotGlyph2,
	output segWord slotGlyph3
);

	// next glyph per slot, slot 0 leftmost
	segWord glyphNext [slotCount];

	// digit to strokes
	// out-of-range values stay dark
	function automatic segWord digitGlyph(bcdDigit d);
		segWord seg;
		if (d <= 4'd9)
			seg = digitGlyphs[d];
		else
			seg = glyphBlank;
		return seg;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// message override
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (atWin)
		begin
			// WIn, the W spans two slots
			glyphNext = '{glyphWHalf, glyphWHalf, glyphI, glyphN};
		end
		else if (atBust)
		begin
			// Urbr
			glyphNext = '{glyphU, glyphR, glyphB, glyphR};
		end
		else
		begin
			glyphNext[0] = digitGlyph(digitThousands);
			glyphNext[1] = digitGlyph(digitHundreds);
			glyphNext[2] = digitGlyph(digitTens);
			glyphNext[3] = digitGlyph(digitOnes);
		end
	end

	// second pipeline stage
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			slotGlyph0 <= glyphBlank;
			slotGlyph1 <= glyphBlank;
			slotGlyph2 <= glyphBlank;
			slotGlyph3 <= glyphBlank;
		end
		else
		begin
			slotGlyph0 <= glyphNext[0];
			slotGlyph1 <= glyphNext[1];
			slotGlyph2 <= glyphNext[2];
			slotGlyph3 <= glyphNext[3];
		end
	end

	// the splitter flags come from disjoint balance ranges
	flagsExclusive: assert property (@(posedge dclk) disable iff (clr)
		!(atWin && atBust));

endmodule

//--- rasterScan.sv
`timescale 1ns/1ps

module rasterScan
	import vgaTimingPkg::*;
#(
	parameter int hTotal = hTotalDefault,
	parameter int vTotal = vTotalDefault,
	parameter int hPulse = hPulseDefault,
	parameter int vPulse = vPulseDefault
)
(
	input logic dclk,
	input logic clr,
	output scanCount hPos,
	output scanCount vPos,
	output logic hsync,
	output logic vsync
);

	// column counter steps every clock
	// line counter steps at the end of each line
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			hPos <= '0;
			vPos <= '0;
		end
		else if (hPos == scanCount'(hTotal - 1))
		begin
			hPos <= '0;
			// last line wraps back to the top
			if (vPos == scanCount'(vTotal - 1))
				vPos <= '0;
			else
				vPos <= vPos + 1'b1;
		end
		else
		begin
			hPos <= hPos + 1'b1;
		end
	end

	// active low, pulse at the start of line and frame
	assign hsync = (hPos >= scanCount'(hPulse));
	assign vsync = (vPos >= scanCount'(vPulse));

	hPosInRange: assert property (@(posedge dclk) disable iff (clr)
		hPos < scanCount'(hTotal));
	vPosInRange: assert property (@(posedge dclk) disable iff (clr)
		vPos < scanCount'(vTotal));

endmodule

//--- digitPainter.sv
`timescale 1ns/1ps

module digitPainter
	import vgaTimingPkg::*;
	import glyphArtPkg::*;
(
	input scanCount hPos,
	input scanCount vPos,
	input segWord slotGlyph0,
	input segWord slotGlyph1,
	input segWord slotGlyph2,
	input segWord slotGlyph3,
	output pixelColor pixelOut
);

	// stroke geometry in counter width
	localparam scanCount strokeW = scanCount'(strokeWidth);
	localparam scanCount topRow = scanCount'(glyphTop);
	localparam scanCount midRow = scanCount'(glyphTop + halfHeight);
	localparam scanCount botRow = scanCount'(glyphTop + 2 * halfHeight);
	localparam scanCount rightCol = scanCount'(slotWidth - strokeWidth);

	segWord glyphs [slotCount];
	// position relative to the top left of the active area
	scanCount hRel;
	scanCount vRel;
	logic inActive;

	assign glyphs[0] = slotGlyph0;
	assign glyphs[1] = slotGlyph1;
	assign glyphs[2] = slotGlyph2;
	assign glyphs[3] = slotGlyph3;

	assign inActive = (hPos >= scanCount'(hBackPorch)) && (hPos < scanCount'(hFrontPorch)) &&
		(vPos >= scanCount'(vBackPorch)) && (vPos < scanCount'(vFrontPorch));
	assign hRel = hPos - scanCount'(hBackPorch);
	assign vRel = vPos - scanCount'(vBackPorch);

	// x is inside the slot, y inside the active area
	function automatic logic strokeLit(segWord seg, scanCount x, scanCount y);
		logic leftEdge;
		logic rightEdge;
		logic upperBand;
		logic lowerBand;
		leftEdge = (x < strokeW);
		rightEdge = (x >= rightCol);
		// vertical strokes sit between the horizontal bars
		upperBand = (y >= topRow + strokeW) && (y < midRow);
		lowerBand = (y >= midRow + strokeW) && (y < botRow);
		return (seg[segTop] && y >= topRow && y < topRow + strokeW) ||
			(seg[segMiddle] && y >= midRow && y < midRow + strokeW) ||
			(seg[segBottom] && y >= botRow && y < botRow + strokeW) ||
			(seg[segUpLeft] && upperBand && leftEdge) ||
			(seg[segUpRight] && upperBand && rightEdge) ||
			(seg[segLowLeft] && lowerBand && leftEdge) ||
			(seg[segLowRight] && lowerBand && rightEdge);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// pixel colour
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// black unless a lit stroke is hit
		pixelOut = '0;
		if (inActive)
		begin
			// columns past the last slot find no match
			for (int s = 0; s < slotCount; s++)
			begin
				if (hRel >= scanCount'(s * slotWidth) && hRel < scanCount'((s + 1) * slotWidth))
				begin
					if (strokeLit(glyphs[s], hRel - scanCount'(s * slotWidth), vRel))
						pixelOut = slotPalette[s];
				end
			end
		end
	end

endmodule

//--- scoreboardVga.sv
`timescale 1ns/1ps

module scoreboardVga
	import vgaTimingPkg::*;
	import glyphArtPkg::*;
#(
	parameter int hTotal = hTotalDefault,
	parameter int vTotal = vTotalDefault,
	parameter int hPulse = hPulseDefault,
	parameter int vPulse = vPulseDefault
)
(
	input logic dclk,
	input logic clr,
	input logic [26:0] balance,
	output logic hsync,
	output logic vsync,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [1:0] blue
);

	// splitter to selector
	bcdDigit digitThousands;
	bcdDigit digitHundreds;
	bcdDigit digitTens;
	bcdDigit digitOnes;
	logic atWin;
	logic atBust;
	// selector to painter
	segWord slotGlyph0;
	segWord slotGlyph1;
	segWord slotGlyph2;
	segWord slotGlyph3;
	// raster to painter
	scanCount hPos;
	scanCount vPos;
	pixelColor pixelOut;

	balanceSplitter splitter (.dclk, .clr, .balance, .digitThousands, .digitHundreds,
		.digitTens, .digitOnes, .atWin, .atBust);

	glyphSelector selector (.dclk, .clr, .digitThousands, .digitHundreds, .digitTens,
		.digitOnes, .atWin, .atBust, .slotGlyph0, .slotGlyph1, .slotGlyph2, .slotGlyph3);

	rasterScan #(.hTotal(hTotal), .vTotal(vTotal), .hPulse(hPulse), .vPulse(vPulse))
		raster (.dclk, .clr, .hPos, .vPos, .hsync, .vsync);

	digitPainter painter (.hPos, .vPos, .slotGlyph0, .slotGlyph1, .slotGlyph2,
		.slotGlyph3, .pixelOut);

	// rrr ggg bb onto the dac pins
	assign red = pixelOut[7:5];
	assign green = pixelOut[4:2];
	assign blue = pixelOut[1:0];

endmodule

//--- tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen
#(
	parameter int halfPeriod = 20,
	parameter int resetCycles = 2
)
(
	output logic dclk,
	output logic clr
);

	// 40 ns period, 25 MHz pixel clock
	initial
	begin
		dclk = 1'b0;
		forever
			#halfPeriod dclk = ~dclk;
	end

	// reset held over the first rising edges
	// released on an edge like the other inputs
	initial
	begin
		clr = 1'b1;
		repeat (resetCycles)
			@(posedge dclk);
		clr <= 1'b0;
	end

endmodule

//--- tbScoreboardVga.sv
`timescale 1ns/1ps

module tbScoreboardVga;

	// raster the DUT is built with
	localparam int hTotal = 800;
	localparam int vTotal = 521;
	localparam int hPulse = 96;
	localparam int vPulse = 2;
	localparam int frameCycles = hTotal * vTotal;
	// syncs, digits, bust, two wins, three random
	localparam int testFrames = 8;
	localparam int timeoutCycles = testFrames * frameCycles + 1000;

	logic dclk;
	logic clr;
	logic [26:0] balance;
	logic hsync;
	logic vsync;
	logic [2:0] red;
	logic [2:0] green;
	logic [1:0] blue;

	// mirrored raster position
	int expH;
	int expV;
	string testName;
	logic [9:0] expWord;
	logic syncFrame = 1'b1;
	int hLowCount = 0;
	int vLowCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount = 0;
	int unsigned rngState = 89623;

	tbClockGen clockGen (.dclk, .clr);

	scoreboardVga #(.hTotal(hTotal), .vTotal(vTotal), .hPulse(hPulse), .vPulse(vPulse))
		i_dut (.dclk, .clr, .balance, .hsync, .vsync, .red, .green, .blue);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// strokes msb first: top, up left, up right, middle, low left, low right, bottom
	function automatic logic [6:0] digitSegments(input int d);
		case (d)
			0: return 7'b1110111;
			1: return 7'b0010010;
			2: return 7'b1011101;
			3: return 7'b1011011;
			4: return 7'b0111010;
			5: return 7'b1101011;
			6: return 7'b1101111;
			7: return 7'b1010010;
			8: return 7'b1111111;
			default: return 7'b1111011;
		endcase
	endfunction

	// message letters or the four digits
	function automatic logic [6:0] expectedGlyph(input int unsigned bal, input int slot);
		// bust shows U r b r
		if (bal == 0)
		begin
			case (slot)
				0: return 7'b0110111;
				2: return 7'b0101111;
				default: return 7'b0001100;
			endcase
		end
		// win shows W W I n, W drawn as two U halves
		if (bal >= 1000)
		begin
			case (slot)
				0, 1: return 7'b0110111;
				2: return digitSegments(1);
				default: return 7'b1110110;
			endcase
		end
		// below 1000 the thousands digit is always 0
		case (slot)
			0: return digitSegments(0);
			1: return digitSegments(int'(bal / 100));
			2: return digitSegments(int'((bal / 10) % 10));
			default: return digitSegments(int'(bal % 10));
		endcase
	endfunction

	// x inside the 80 wide slot, y below the first active line
	function automatic logic strokeHit(input logic [6:0] seg, input int x, input int y);
		logic upper;
		logic lower;
		upper = (y >= 260 && y <= 334);
		lower = (y >= 340 && y <= 414);
		return (seg[6] && y >= 255 && y <= 259) || (seg[3] && y >= 335 && y <= 339) ||
			(seg[0] && y >= 415 && y <= 419) || (seg[5] && upper && x < 5) ||
			(seg[4] && upper && x >= 75) || (seg[2] && lower && x < 5) ||
			(seg[1] && lower && x >= 75);
	endfunction

	// rrr ggg bb
	function automatic logic [7:0] slotColour(input int slot);
		case (slot)
			0: return {3'd7, 3'd7, 2'd3};
			1: return {3'd7, 3'd7, 2'd0};
			2: return {3'd0, 3'd7, 2'd3};
			default: return {3'd0, 3'd7, 2'd0};
		endcase
	endfunction

	// {hsync, vsync, colour} for one raster position
	function automatic logic [9:0] referenceOutputs(input int h, input int v,
		input int unsigned bal);
		logic [7:0] colour;
		int slot;
		colour = 8'h00;
		// active area, columns 144 to 783 and lines 31 to 510
		if (h >= 144 && h < 784 && v >= 31 && v < 511)
		begin
			slot = (h - 144) / 80;
			// columns past the fourth slot stay black
			if (slot < 4 && strokeHit(expectedGlyph(bal, slot), (h - 144) % 80, v - 31))
				colour = slotColour(slot);
		end
		return {h >= hPulse, v >= vPulse, colour};
	endfunction

	function automatic int unsigned nextRandom(input int unsigned state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// returns on the edge that wraps to column 0, line 0
	task automatic waitFrameEnd();
		do
			@(posedge dclk);
		while (!(expH == hTotal - 1 && expV == vTotal - 1));
	endtask

	// called on the wrap edge, glyphs settle before any visible pixel
	task automatic applyBalance(input string name, input int unsigned value);
		balance <= 27'(value);
		testName = name;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// position mirror, compare and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			expH <= 0;
			expV <= 0;
		end
		else if (expH == hTotal - 1)
		begin
			expH <= 0;
			expV <= (expV == vTotal - 1) ? 0 : expV + 1;
		end
		else
			expH <= expH + 1;
	end

	// outputs are settled at the falling edge
	always @(negedge dclk)
	begin
		if (!clr)
		begin
			expWord = referenceOutputs(expH, expV, 32'(balance));
			checkValue(testName, 32'(expWord), 32'({hsync, vsync, red, green, blue}));
			if (syncFrame && !hsync)
				hLowCount++;
			if (syncFrame && !vsync)
				vLowCount++;
			// first frame done, sync pulse totals
			if (syncFrame && expH == hTotal - 1 && expV == vTotal - 1)
			begin
				checkValue("syncs hsync low cycles", 32'(hPulse * vTotal), 32'(hLowCount));
				checkValue("syncs vsync low cycles", 32'(vPulse * hTotal), 32'(vLowCount));
				syncFrame = 1'b0;
			end
		end
	end

	always @(posedge dclk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout: tests did not finish within %0d cycles", timeoutCycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus, one frame per test
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		balance = '0;
		testName = "syncs";
		@(negedge clr);
		// frame one runs the bust balance and counts syncs
		waitFrameEnd();
		applyBalance("digits", 427);
		waitFrameEnd();
		applyBalance("bust", 0);
		waitFrameEnd();
		applyBalance("win 1000", 1000);
		waitFrameEnd();
		applyBalance("win 54321", 54321);
		waitFrameEnd();
		repeat (3)
		begin
			rngState = nextRandom(rngState);
			applyBalance("random", (rngState >> 16) % 1000);
			waitFrameEnd();
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- filelist.f
vgaTimingPkg.sv
glyphArtPkg.sv
balanceSplitter.sv
glyphSelector.sv
rasterScan.sv
digitPainter.sv
scoreboardVga.sv
tbClockGen.sv
tbScoreboardVga.sv

//--- Makefile
TOOL = verilator
TOP = tbScoreboardVga
FILELIST = filelist.f
FLAGS = --binary --timing --assert -j 0
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
